// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module pipe_core_tb \
    -f src.f -o pipe_core_sim

# the simulator stops with a non-zero status on failure, the log decides
./obj_dir/pipe_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
if ! grep -q "all tests passed" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation PASSED"

// File: src.f
+incdir+verilog
verilog/core_pkg.sv
verilog/host_regs.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/id_ex.sv
verilog/execute_stage.sv
verilog/pipe_core_top.sv
tests/pipe_core_tb.sv

// File: tests/pipe_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_config.svh"

module pipe_core_tb;

    localparam int CLK_PERIOD   = 100;
    localparam int NUM_BURSTS   = 60;
    localparam int MAX_BURST    = 8;
    // directed accesses plus, per burst, instructions, stray writes and six reads
    localparam int MAX_ACCESSES = 80 + NUM_BURSTS * (2 * MAX_BURST + 6);
    // a read waits at most for the issue slot and execute to drain
    localparam int TIMEOUT_CYCLES = 20 + MAX_ACCESSES * 4;

    logic                   clk;
    logic                   rst_n;
    core_pkg::wb_req_t      bus;
    core_pkg::wb_rsp_t      rsp;

    logic [`WORD_SIZE-1:0]  model_regs [`NUM_REGS];
    logic [`WORD_SIZE-1:0]  model_count;
    int                     max_stall;

    pipe_core_top i_pipe_core_top (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus),
        .rsp   (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("tests failed");
        $fatal(1);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [15:0] enc_r(input logic [5:0] funct, input logic [1:0] rs,
                                          input logic [1:0] rt, input logic [1:0] rd);
        return {4'(core_pkg::OP_RTYPE), rs, rt, rd, funct};
    endfunction

    function automatic logic [15:0] enc_i(input logic [3:0] op, input logic [1:0] rs,
                                          input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // every instruction retires, only known encodings write a register
    task automatic model_apply(input logic [15:0] w);
        logic [`WORD_SIZE-1:0] s;
        logic [`WORD_SIZE-1:0] t;
        logic [7:0]            imm;
        s   = model_regs[w[11:10]];
        t   = model_regs[w[9:8]];
        imm = w[7:0];
        case (w[15:12])
            core_pkg::OP_RTYPE: begin
                case (w[5:0])
                    6'd0: model_regs[w[7:6]] = s + t;
                    6'd1: model_regs[w[7:6]] = s - t;
                    6'd2: model_regs[w[7:6]] = s & t;
                    6'd3: model_regs[w[7:6]] = s | t;
                    6'd4: model_regs[w[7:6]] = s ^ t;
                    default: ;
                endcase
            end
            core_pkg::OP_ADDI: model_regs[w[9:8]] = s + {{8{imm[7]}}, imm};
            core_pkg::OP_ORI:  model_regs[w[9:8]] = s | {8'h00, imm};
            core_pkg::OP_LHI:  model_regs[w[9:8]] = {imm, 8'h00};
            default: ;
        endcase
        model_count = model_count + 16'd1;
    endtask

    function automatic logic [15:0] random_instr();
        int         sel;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [1:0] rd;
        sel = $urandom % 10;
        rs  = 2'($urandom);
        rt  = 2'($urandom);
        rd  = 2'($urandom);
        case (sel)
            0, 1, 2: return enc_r(6'($urandom % 6), rs, rt, rd);
            3:       return enc_r(6'($urandom), rs, rt, rd);
            4, 5:    return enc_i(core_pkg::OP_ADDI, rs, rt, 8'($urandom));
            6:       return enc_i(core_pkg::OP_ORI, rs, rt, 8'($urandom));
            7:       return enc_i(core_pkg::OP_LHI, rs, rt, 8'($urandom));
            default: return 16'($urandom);
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus access and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_eq(input string what, input logic [15:0] expected,
                            input logic [15:0] actual);
        assert (actual === expected) else begin
            $display("ERROR %s expected %h actual %h", what, expected, actual);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic bus_write(input logic [`WB_ADR_W-1:0] adr, input logic [15:0] data);
        @(posedge clk);
        bus <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat_w: data};
        @(negedge clk);
        assert (rsp.ack) else begin
            $display("write to address %0d was not acknowledged in its first cycle", adr);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic bus_read(input logic [`WB_ADR_W-1:0] adr, output logic [15:0] data);
        int waited;
        waited = 0;
        @(posedge clk);
        bus <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat_w: 16'h0000};
        @(negedge clk);
        while (!rsp.ack) begin
            waited++;
            @(negedge clk);
        end
        data = rsp.dat_r;
        if (waited > max_stall) begin
            max_stall = waited;
        end
    endtask

    task automatic issue_instr(input logic [15:0] w);
        bus_write(`ADR_INSTR, w);
        model_apply(w);
    endtask

    task automatic check_reg(input int idx);
        logic [15:0] got;
        bus_read(`ADR_REG_BASE + `WB_ADR_W'(idx), got);
        check_eq($sformatf("rsp.dat_r (r%0d)", idx), model_regs[idx], got);
    endtask

    // the count is read first, straight after the last instruction
    task automatic check_all();
        logic [15:0] got;
        bus_read(`ADR_RETIRED, got);
        check_eq("rsp.dat_r (retired count)", model_count, got);
        bus_read(`ADR_INSTR, got);
        check_eq("rsp.dat_r (address 0)", 16'h0000, got);
        for (int k = 0; k < `NUM_REGS; k++) begin
            check_reg(k);
        end
    endtask

    initial begin
        int len;
        void'($urandom(32'hf062));
        rst_n       = 1'b0;
        bus         = '0;
        model_count = '0;
        max_stall   = 0;
        for (int k = 0; k < `NUM_REGS; k++) begin
            model_regs[k] = '0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        check_all();

        // load known patterns, then each operation on its own
        issue_instr(enc_i(core_pkg::OP_LHI, 2'd0, 2'd1, 8'h12));
        check_reg(1);
        issue_instr(enc_i(core_pkg::OP_ORI, 2'd1, 2'd1, 8'hf0));
        check_reg(1);
        issue_instr(enc_i(core_pkg::OP_LHI, 2'd0, 2'd2, 8'ha5));
        check_reg(2);
        issue_instr(enc_i(core_pkg::OP_ADDI, 2'd2, 2'd2, 8'h3c));
        check_reg(2);
        // negative immediate must be sign extended
        issue_instr(enc_i(core_pkg::OP_ADDI, 2'd1, 2'd3, 8'h80));
        check_reg(3);
        issue_instr(enc_i(core_pkg::OP_ORI, 2'd0, 2'd0, 8'hff));
        check_reg(0);
        for (int f = 0; f < 5; f++) begin
            issue_instr(enc_r(6'(f), 2'd1, 2'd2, 2'(f)));
            check_reg(f % `NUM_REGS);
            issue_instr(enc_i(core_pkg::OP_LHI, 2'd0, 2'(f), 8'(8'h31 + f)));
            check_reg(f % `NUM_REGS);
        end
        issue_instr(enc_r(6'd9, 2'd1, 2'd2, 2'd3));
        issue_instr({4'h2, 12'habc});
        check_all();

        // stray writes to every other address
        for (int a = 1; a < 8; a++) begin
            bus_write(`WB_ADR_W'(a), 16'hdead);
        end
        check_all();

        for (int n = 0; n < NUM_BURSTS; n++) begin
            len = 1 + $urandom % MAX_BURST;
            for (int k = 0; k < len; k++) begin
                if ($urandom % 4 == 0) begin
                    bus_write(`WB_ADR_W'(1 + $urandom % 7), 16'($urandom));
                end
                issue_instr(random_instr());
            end
            check_all();
        end

        @(posedge clk);
        bus <= '0;
        @(posedge clk);
        $display("longest read stall %0d cycles, %0d instructions", max_stall, model_count);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/core_config.svh
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// datapath and register file
`define WORD_SIZE 16
`define NUM_REGS 4
`define REG_IDX_W 2

// host bus address map
`define WB_ADR_W 3
`define ADR_INSTR 3'd0
`define ADR_RETIRED 3'd1
// r0 to r3 sit at addresses 4 to 7
`define ADR_REG_BASE 3'd4

`endif

// File: verilog/core_pkg.sv
`default_nettype none

`include "core_config.svh"

package core_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction encoding
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [3:0] {
        OP_ADDI  = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_RTYPE = 4'd15
    } opcode_t;

    typedef enum logic [5:0] {
        F_ADD = 6'd0,
        F_SUB = 6'd1,
        F_AND = 6'd2,
        F_OR  = 6'd3,
        F_XOR = 6'd4
    } funct_t;

    typedef struct packed {
        opcode_t                opcode;
        logic [`REG_IDX_W-1:0]  rs;
        logic [`REG_IDX_W-1:0]  rt;
        logic [`REG_IDX_W-1:0]  rd;
        funct_t                 funct;
    } r_fmt_t;

    // rt is the destination in this format
    typedef struct packed {
        opcode_t                opcode;
        logic [`REG_IDX_W-1:0]  rs;
        logic [`REG_IDX_W-1:0]  rt;
        logic [7:0]             imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_LHI = 3'd5
    } alu_op_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline and bus bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // b already holds either rt or the extended immediate
    typedef struct packed {
        logic                   valid;
        logic [`WORD_SIZE-1:0]  a;
        logic [`WORD_SIZE-1:0]  b;
        logic [`REG_IDX_W-1:0]  rd;
        alu_op_t                alu_op;
        logic                   reg_write;
    } id_ex_t;

    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`WB_ADR_W-1:0]   adr;
        logic [`WORD_SIZE-1:0]  dat_w;
    } wb_req_t;

    typedef struct packed {
        logic                   ack;
        logic [`WORD_SIZE-1:0]  dat_r;
    } wb_rsp_t;

    typedef struct packed {
        logic                   en;
        logic [`REG_IDX_W-1:0]  idx;
        logic [`WORD_SIZE-1:0]  data;
    } reg_wr_t;

endpackage

`default_nettype wire

// File: verilog/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_config.svh"

module decode_stage (
    input  wire core_pkg::instr_t       instr,
    input  wire                         instr_valid,
    output logic [`REG_IDX_W-1:0]       rs_idx,
    output logic [`REG_IDX_W-1:0]       rt_idx,
    input  wire  [`WORD_SIZE-1:0]       rs_data,
    input  wire  [`WORD_SIZE-1:0]       rt_data,
    input  wire core_pkg::reg_wr_t      fwd,
    output core_pkg::id_ex_t            dec
);

    logic [`WORD_SIZE-1:0] op_s;
    logic [`WORD_SIZE-1:0] op_t;

    // rs and rt sit at the same bits in both formats
    assign rs_idx = instr.r.rs;
    assign rt_idx = instr.r.rt;

    // the instruction in execute has not written back yet, take its result
    assign op_s = (fwd.en && fwd.idx == instr.r.rs) ? fwd.data : rs_data;
    assign op_t = (fwd.en && fwd.idx == instr.r.rt) ? fwd.data : rt_data;

    always_comb begin
        dec           = '0;
        dec.valid     = instr_valid;
        dec.a         = op_s;
        dec.b         = op_t;
        dec.rd        = instr.i.rt;
        dec.alu_op    = core_pkg::ALU_ADD;
        dec.reg_write = 1'b0;
        case (instr.r.opcode)
            core_pkg::OP_RTYPE: begin
                dec.rd        = instr.r.rd;
                dec.reg_write = 1'b1;
                case (instr.r.funct)
                    core_pkg::F_ADD: dec.alu_op = core_pkg::ALU_ADD;
                    core_pkg::F_SUB: dec.alu_op = core_pkg::ALU_SUB;
                    core_pkg::F_AND: dec.alu_op = core_pkg::ALU_AND;
                    core_pkg::F_OR:  dec.alu_op = core_pkg::ALU_OR;
                    core_pkg::F_XOR: dec.alu_op = core_pkg::ALU_XOR;
                    default:         dec.reg_write = 1'b0;
                endcase
            end
            core_pkg::OP_ADDI: begin
                dec.b         = {{(`WORD_SIZE-8){instr.i.imm[7]}}, instr.i.imm};
                dec.reg_write = 1'b1;
            end
            core_pkg::OP_ORI: begin
                dec.b         = {{(`WORD_SIZE-8){1'b0}}, instr.i.imm};
                dec.alu_op    = core_pkg::ALU_OR;
                dec.reg_write = 1'b1;
            end
            core_pkg::OP_LHI: begin
                dec.b         = {instr.i.imm, {(`WORD_SIZE-8){1'b0}}};
                dec.alu_op    = core_pkg::ALU_LHI;
                dec.reg_write = 1'b1;
            end
            default: begin
                // unknown opcode goes down the pipe as a nop
                dec.reg_write = 1'b0;
            end
        endcase
        dec.reg_write = dec.reg_write && instr_valid;
    end

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_config.svh"

module execute_stage (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire core_pkg::id_ex_t       ex,
    output core_pkg::reg_wr_t           wr,
    output logic                        retired,
    output logic                        busy
);

    logic [`WORD_SIZE-1:0] result;

    always_comb begin
        case (ex.alu_op)
            core_pkg::ALU_ADD: result = ex.a + ex.b;
            core_pkg::ALU_SUB: result = ex.a - ex.b;
            core_pkg::ALU_AND: result = ex.a & ex.b;
            core_pkg::ALU_OR:  result = ex.a | ex.b;
            core_pkg::ALU_XOR: result = ex.a ^ ex.b;
            // decode has already placed the immediate in the high byte
            core_pkg::ALU_LHI: result = ex.b;
            default:           result = '0;
        endcase
    end

    // the register file takes this at the edge closing the execute cycle,
    // and decode sees it in the same cycle as its forward source
    assign wr.en   = ex.valid && ex.reg_write;
    assign wr.idx  = ex.rd;
    assign wr.data = result;

    assign retired = ex.valid;
    assign busy    = ex.valid;

    // operands come from the register file or the forward path
    result_known: assert property (@(posedge clk) disable iff (!rst_n)
        wr.en |-> !$isunknown(wr.data));

endmodule

`default_nettype wire

// File: verilog/host_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_config.svh"

module host_regs (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire core_pkg::wb_req_t      bus,
    output core_pkg::wb_rsp_t           rsp,
    output core_pkg::instr_t            issue,
    output logic                        issue_valid,
    input  wire core_pkg::reg_wr_t      retire,
    input  wire                         retire_valid,
    input  wire                         ex_busy,
    output logic [`REG_IDX_W-1:0]       reg_rd_idx,
    input  wire  [`WORD_SIZE-1:0]       reg_rd_data
);

    logic                   access;
    logic                   wr_ack;
    logic                   rd_ack;
    logic                   instr_wr;
    logic [`WB_ADR_W-1:0]   reg_off;
    logic [`WORD_SIZE-1:0]  retired_cnt;

    assign access   = bus.cyc && bus.stb;
    // writes never stall, one instruction per cycle can go in
    assign wr_ack   = access && bus.we;
    // hold reads until nothing is left in flight so register data is final
    assign rd_ack   = access && !bus.we && !issue_valid && !ex_busy;
    assign instr_wr = wr_ack && (bus.adr == `ADR_INSTR);

    assign reg_off    = bus.adr - `ADR_REG_BASE;
    assign reg_rd_idx = reg_off[`REG_IDX_W-1:0];

    always_comb begin
        rsp.ack   = wr_ack || rd_ack;
        rsp.dat_r = '0;
        if (reg_off < `WB_ADR_W'(`NUM_REGS)) begin
            rsp.dat_r = reg_rd_data;
        end else if (bus.adr == `ADR_RETIRED) begin
            rsp.dat_r = retired_cnt;
        end
    end

    // the slot is emptied by decode in the very next cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= instr_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_wr) begin
            issue <= bus.dat_w;
        end
    end

    // nops retire too, so count every valid instruction leaving execute
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retired_cnt <= '0;
        end else if (retire_valid || retire.en) begin
            retired_cnt <= retired_cnt + 1'b1;
        end
    end

    ack_needs_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rsp.ack) |-> bus.cyc && bus.stb);

endmodule

`default_nettype wire

// File: verilog/id_ex.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_config.svh"

module id_ex (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire core_pkg::id_ex_t       d,
    output core_pkg::id_ex_t            q
);

    logic               valid_q;
    logic               reg_write_q;
    core_pkg::id_ex_t   data_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q     <= 1'b0;
            reg_write_q <= 1'b0;
        end else begin
            valid_q     <= d.valid;
            reg_write_q <= d.reg_write;
        end
    end

    // operands, destination and ALU op
    always_ff @(posedge clk) begin
        data_q <= d;
    end

    always_comb begin
        q           = data_q;
        q.valid     = valid_q;
        q.reg_write = reg_write_q;
    end

    alu_op_known: assert property (@(posedge clk) disable iff (!rst_n)
        q.valid |-> !$isunknown(q.alu_op));

endmodule

`default_nettype wire

// File: verilog/pipe_core_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_config.svh"

module pipe_core_top (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire core_pkg::wb_req_t      bus,
    output core_pkg::wb_rsp_t           rsp
);

    core_pkg::instr_t       issue;
    logic                   issue_valid;
    logic [`REG_IDX_W-1:0]  rs_idx;
    logic [`REG_IDX_W-1:0]  rt_idx;
    logic [`REG_IDX_W-1:0]  host_idx;
    logic [`WORD_SIZE-1:0]  rs_data;
    logic [`WORD_SIZE-1:0]  rt_data;
    logic [`WORD_SIZE-1:0]  host_data;
    core_pkg::id_ex_t       dec;
    core_pkg::id_ex_t       ex;
    core_pkg::reg_wr_t      wr;
    logic                   retired;
    logic                   busy;

    host_regs i_host_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus          (bus),
        .rsp          (rsp),
        .issue        (issue),
        .issue_valid  (issue_valid),
        .retire       (wr),
        .retire_valid (retired),
        .ex_busy      (busy),
        .reg_rd_idx   (host_idx),
        .reg_rd_data  (host_data)
    );

    reg_file i_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs_idx    (rs_idx),
        .rt_idx    (rt_idx),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .host_idx  (host_idx),
        .host_data (host_data),
        .wr        (wr)
    );

    decode_stage i_decode_stage (
        .instr       (issue),
        .instr_valid (issue_valid),
        .rs_idx      (rs_idx),
        .rt_idx      (rt_idx),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .fwd         (wr),
        .dec         (dec)
    );

    id_ex i_id_ex (
        .clk   (clk),
        .rst_n (rst_n),
        .d     (dec),
        .q     (ex)
    );

    execute_stage i_execute_stage (
        .clk     (clk),
        .rst_n   (rst_n),
        .ex      (ex),
        .wr      (wr),
        .retired (retired),
        .busy    (busy)
    );

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_config.svh"

module reg_file (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire  [`REG_IDX_W-1:0]       rs_idx,
    input  wire  [`REG_IDX_W-1:0]       rt_idx,
    output logic [`WORD_SIZE-1:0]       rs_data,
    output logic [`WORD_SIZE-1:0]       rt_data,
    input  wire  [`REG_IDX_W-1:0]       host_idx,
    output logic [`WORD_SIZE-1:0]       host_data,
    input  wire core_pkg::reg_wr_t      wr
);

    logic [`WORD_SIZE-1:0] regs [`NUM_REGS];

    // writes land at the edge closing the execute cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < `NUM_REGS; k++) begin
                regs[k] <= '0;
            end
        end else if (wr.en) begin
            regs[wr.idx] <= wr.data;
        end
    end

    // two ports for decode, one for the host
    assign rs_data   = regs[rs_idx];
    assign rt_data   = regs[rt_idx];
    assign host_data = regs[host_idx];

endmodule

`default_nettype wire
